/* mips_isa_pkg.sv */
package mips_isa_pkg;

    localparam int word_w   = 32;
    localparam int reg_w    = 5;
    localparam int op_w     = 6;
    localparam int fn_w     = 6;
    localparam int shamt_w  = 5;
    localparam int imm_w    = 16;  // also the branch offset
    localparam int target_w = 26;  // j, jal

    localparam int op_lsb    = 26;
    localparam int rs_lsb    = 21;
    localparam int rt_lsb    = 16;
    localparam int rd_lsb    = 11;
    localparam int shamt_lsb = 6;  // funct, imm and target sit at bit 0

    typedef logic [reg_w-1:0]  reg_addr_t;
    typedef logic [word_w-1:0] word_t;

    typedef enum logic [op_w-1:0] {
        op_special = 6'b000000,  // r-type, see funct
        op_j       = 6'b000010,
        op_jal     = 6'b000011,
        op_beq     = 6'b000100,
        op_bne     = 6'b000101,
        op_addi    = 6'b001000,
        op_andi    = 6'b001100,
        op_ori     = 6'b001101,
        op_xori    = 6'b001110,
        op_lui     = 6'b001111,
        op_lw      = 6'b100011,
        op_sw      = 6'b101011
    } opcode_e;

    typedef enum logic [fn_w-1:0] {
        fn_sll = 6'b000000,
        fn_srl = 6'b000010,
        fn_sra = 6'b000011,
        fn_jr  = 6'b001000,
        fn_add = 6'b100000,
        fn_sub = 6'b100010,
        fn_and = 6'b100100,
        fn_or  = 6'b100101,
        fn_xor = 6'b100110
    } funct_e;

    typedef enum logic [4:0] {
        instr_add, instr_sub, instr_and, instr_or, instr_xor,
        instr_sll, instr_srl, instr_sra, instr_jr,
        instr_addi, instr_andi, instr_ori, instr_xori,
        instr_lw, instr_sw, instr_beq, instr_bne, instr_lui,
        instr_j, instr_jal,
        instr_illegal
    } instr_e;

    localparam reg_addr_t link_reg = 5'd31;  // jal return address

endpackage

/* id_ctrl_pkg.sv */
package id_ctrl_pkg;

    typedef enum logic [4:0] {
        alu_nop,  // zero value, also the reset value
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lw,
        alu_sw,
        alu_beq,
        alu_bne,
        alu_lui,
        alu_j,
        alu_jal,
        alu_jr
    } alu_op_e;

    // pc and zero are needed by j, jal and illegal
    typedef enum logic [2:0] {
        a_rs,
        a_shamt,
        a_offset,
        a_lui,
        a_pc,
        a_zero
    } op_a_sel_e;

    typedef enum logic [2:0] {
        b_rt,
        b_imm_sign,
        b_imm_zero,
        b_target,
        b_four,
        b_pc,
        b_zero
    } op_b_sel_e;

    typedef enum logic [1:0] {
        wb_none,
        wb_alu,
        wb_mem
    } wb_sel_e;

    typedef struct packed {
        alu_op_e                alu_op;
        op_a_sel_e              a_sel;
        op_b_sel_e              b_sel;
        logic                   mem_rd;
        logic                   mem_wr;
        logic                   reg_wr;
        wb_sel_e                wb_sel;
        mips_isa_pkg::reg_addr_t reg_target;
    } ctrl_t;

    typedef struct packed {
        alu_op_e                 alu_op;
        mips_isa_pkg::word_t     op_a;
        mips_isa_pkg::word_t     op_b;
        logic                    mem_rd;
        logic                    mem_wr;
        logic                    reg_wr;
        wb_sel_e                 wb_sel;
        mips_isa_pkg::reg_addr_t reg_target;
        logic                    jump_en;
    } issue_t;

endpackage

/* instr_classifier.sv */
`timescale 1ns/1ps

module instr_classifier (
    input  mips_isa_pkg::word_t  inst,
    output mips_isa_pkg::instr_e instr
);
    import mips_isa_pkg::*;

    opcode_e   opcode;
    funct_e    funct;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    logic [shamt_w-1:0] shamt;

    logic shamt_zero;
    logic rs_zero;
    logic jr_zero;

    assign opcode = opcode_e'(inst[op_lsb +: op_w]);
    assign funct  = funct_e'(inst[fn_w-1:0]);
    assign rs     = inst[rs_lsb +: reg_w];
    assign rt     = inst[rt_lsb +: reg_w];
    assign rd     = inst[rd_lsb +: reg_w];
    assign shamt  = inst[shamt_lsb +: shamt_w];

    // fixed-zero field checks
    assign shamt_zero = (shamt == '0);
    assign rs_zero    = (rs == '0);
    assign jr_zero    = (rt == '0) && (rd == '0) && shamt_zero;

    // r-type: function field
    always_comb begin
        instr = instr_illegal;
        case (opcode)
            op_special: begin
                case (funct)
                    fn_add: if (shamt_zero) instr = instr_add;
                    fn_sub: if (shamt_zero) instr = instr_sub;
                    fn_and: if (shamt_zero) instr = instr_and;
                    fn_or:  if (shamt_zero) instr = instr_or;
                    fn_xor: if (shamt_zero) instr = instr_xor;
                    fn_sll: if (rs_zero) instr = instr_sll;
                    fn_srl: if (rs_zero) instr = instr_srl;
                    fn_sra: if (rs_zero) instr = instr_sra;
                    fn_jr:  if (jr_zero) instr = instr_jr;
                    default: instr = instr_illegal;
                endcase
            end
            op_addi: instr = instr_addi;
            op_andi: instr = instr_andi;
            op_ori:  instr = instr_ori;
            op_xori: instr = instr_xori;
            op_lw:   instr = instr_lw;
            op_sw:   instr = instr_sw;
            op_beq:  instr = instr_beq;
            op_bne:  instr = instr_bne;
            op_lui: begin
                if (rs_zero) begin  // lui has no source register
                    instr = instr_lui;
                end
            end
            op_j:    instr = instr_j;
            op_jal:  instr = instr_jal;
            default: instr = instr_illegal;  // unknown opcode
        endcase
    end

endmodule

/* ctrl_table.sv */
`timescale 1ns/1ps

module ctrl_table (
    input  mips_isa_pkg::instr_e instr,
    input  mips_isa_pkg::word_t  inst,
    output id_ctrl_pkg::ctrl_t   ctrl
);
    import mips_isa_pkg::*;
    import id_ctrl_pkg::*;

    reg_addr_t rt;
    reg_addr_t rd;
    alu_op_e   alu_op;

    assign rt = inst[rt_lsb +: reg_w];
    assign rd = inst[rd_lsb +: reg_w];

    // immediate forms share the op of their r-type partner
    always_comb begin
        case (instr)
            instr_add, instr_addi: alu_op = alu_add;
            instr_sub:             alu_op = alu_sub;
            instr_and, instr_andi: alu_op = alu_and;
            instr_or, instr_ori:   alu_op = alu_or;
            instr_xor, instr_xori: alu_op = alu_xor;
            instr_sll:             alu_op = alu_sll;
            instr_srl:             alu_op = alu_srl;
            instr_sra:             alu_op = alu_sra;
            instr_lw:              alu_op = alu_lw;
            instr_sw:              alu_op = alu_sw;
            instr_beq:             alu_op = alu_beq;
            instr_bne:             alu_op = alu_bne;
            instr_lui:             alu_op = alu_lui;
            instr_j:               alu_op = alu_j;
            instr_jal:             alu_op = alu_jal;
            instr_jr:              alu_op = alu_jr;
            default:               alu_op = alu_nop;
        endcase
    end

    always_comb begin
        ctrl.alu_op     = alu_op;
        ctrl.a_sel      = a_zero;
        ctrl.b_sel      = b_zero;
        ctrl.mem_rd     = 1'b0;
        ctrl.mem_wr     = 1'b0;
        ctrl.reg_wr     = 1'b0;
        ctrl.wb_sel     = wb_none;
        ctrl.reg_target = '0;  // non-writers leave target at zero
        case (instr)
            instr_add, instr_sub, instr_and, instr_or, instr_xor,
            instr_sll, instr_srl, instr_sra: begin
                ctrl.a_sel      = (alu_op inside {alu_sll, alu_srl, alu_sra}) ? a_shamt : a_rs;
                ctrl.b_sel      = b_rt;
                ctrl.reg_wr     = 1'b1;
                ctrl.wb_sel     = wb_alu;
                ctrl.reg_target = rd;
            end
            instr_addi, instr_andi, instr_ori, instr_xori: begin
                ctrl.a_sel      = a_rs;
                ctrl.b_sel      = (instr == instr_addi) ? b_imm_sign : b_imm_zero;
                ctrl.reg_wr     = 1'b1;
                ctrl.wb_sel     = wb_alu;
                ctrl.reg_target = rt;
            end
            instr_lui: begin
                ctrl.a_sel      = a_lui;
                ctrl.reg_wr     = 1'b1;
                ctrl.wb_sel     = wb_alu;
                ctrl.reg_target = rt;
            end
            instr_lw: begin
                ctrl.a_sel      = a_rs;  // base
                ctrl.b_sel      = b_imm_sign;
                ctrl.mem_rd     = 1'b1;
                ctrl.reg_wr     = 1'b1;
                ctrl.wb_sel     = wb_mem;
                ctrl.reg_target = rt;
            end
            instr_sw: begin
                ctrl.a_sel  = a_rs;
                ctrl.b_sel  = b_imm_sign;
                ctrl.mem_wr = 1'b1;
            end
            instr_beq, instr_bne: begin
                ctrl.a_sel = a_offset;  // target adder inputs
                ctrl.b_sel = b_pc;
            end
            instr_j: begin
                ctrl.a_sel = a_pc;
                ctrl.b_sel = b_target;
            end
            instr_jal: begin
                ctrl.a_sel      = a_pc;  // link value pc + 4
                ctrl.b_sel      = b_four;
                ctrl.reg_wr     = 1'b1;
                ctrl.wb_sel     = wb_alu;
                ctrl.reg_target = link_reg;
            end
            instr_jr: ctrl.a_sel = a_rs;
            default: ;
        endcase
    end

    always_comb begin
        assert final (!(ctrl.mem_rd && ctrl.mem_wr))
            else $error("ctrl_table: load and store enabled together");
    end

endmodule

/* operand_select.sv */
`timescale 1ns/1ps

module operand_select (
    input  id_ctrl_pkg::ctrl_t  ctrl,
    input  mips_isa_pkg::word_t inst,
    input  mips_isa_pkg::word_t pc,
    input  mips_isa_pkg::word_t rs_data,
    input  mips_isa_pkg::word_t rt_data,
    output mips_isa_pkg::word_t op_a,
    output mips_isa_pkg::word_t op_b
);
    import mips_isa_pkg::*;
    import id_ctrl_pkg::*;

    word_t imm_sext;
    word_t imm_zext;
    word_t imm_upper;
    word_t shamt_zext;
    word_t target_zext;

    assign imm_sext    = {{(word_w-imm_w){inst[imm_w-1]}}, inst[imm_w-1:0]};
    assign imm_zext    = {{(word_w-imm_w){1'b0}}, inst[imm_w-1:0]};
    assign imm_upper   = {inst[imm_w-1:0], {(word_w-imm_w){1'b0}}};  // lui
    assign shamt_zext  = {{(word_w-shamt_w){1'b0}}, inst[shamt_lsb +: shamt_w]};
    assign target_zext = {{(word_w-target_w){1'b0}}, inst[target_w-1:0]};

    always_comb begin
        case (ctrl.a_sel)
            a_rs:     op_a = rs_data;
            a_shamt:  op_a = shamt_zext;
            a_offset: op_a = imm_sext;  // branch offset
            a_lui:    op_a = imm_upper;
            a_pc:     op_a = pc;
            default:  op_a = '0;
        endcase
    end

    always_comb begin
        case (ctrl.b_sel)
            b_rt:       op_b = rt_data;
            b_imm_sign: op_b = imm_sext;
            b_imm_zero: op_b = imm_zext;
            b_target:   op_b = target_zext;  // jump target, unshifted
            b_four:     op_b = word_t'(4);
            b_pc:       op_b = pc;
            default:    op_b = '0;
        endcase
    end

endmodule

/* id_issue.sv */
`timescale 1ns/1ps

module id_issue (
    input  logic                clk,
    input  logic                reset,
    input  logic                inst_valid,
    input  id_ctrl_pkg::ctrl_t  ctrl,
    input  mips_isa_pkg::word_t op_a,
    input  mips_isa_pkg::word_t op_b,
    input  mips_isa_pkg::word_t rs_data,
    input  mips_isa_pkg::word_t rt_data,
    output logic                issue_valid,
    output id_ctrl_pkg::issue_t issue
);
    import id_ctrl_pkg::*;

    logic jump_en;

    // branches compare register data, not the operands
    always_comb begin
        case (ctrl.alu_op)
            alu_beq:                jump_en = (rs_data == rt_data);
            alu_bne:                jump_en = (rs_data != rt_data);
            alu_j, alu_jal, alu_jr: jump_en = 1'b1;
            default:                jump_en = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            issue_valid <= 1'b0;
            issue       <= '0;
        end else begin
            issue_valid <= inst_valid;
            if (inst_valid) begin  // bundle holds between strobes
                issue <= '{alu_op:     ctrl.alu_op,
                           op_a:       op_a,
                           op_b:       op_b,
                           mem_rd:     ctrl.mem_rd,
                           mem_wr:     ctrl.mem_wr,
                           reg_wr:     ctrl.reg_wr,
                           wb_sel:     ctrl.wb_sel,
                           reg_target: ctrl.reg_target,
                           jump_en:    jump_en};
            end
        end
    end

    // a strobe seen during reset must not leak out as an issue
    assert property (@(posedge clk) reset |=> !issue_valid)
        else $error("id_issue: issue_valid high right after reset");

endmodule

/* id_stage.sv */
`timescale 1ns/1ps

module id_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    inst_valid,
    input  mips_isa_pkg::word_t     inst,
    input  mips_isa_pkg::word_t     pc,
    input  mips_isa_pkg::word_t     rs_data,
    input  mips_isa_pkg::word_t     rt_data,
    output mips_isa_pkg::reg_addr_t rs_addr,
    output mips_isa_pkg::reg_addr_t rt_addr,
    output logic                    issue_valid,
    output id_ctrl_pkg::issue_t     issue
);
    import mips_isa_pkg::*;
    import id_ctrl_pkg::*;

    instr_e instr;
    ctrl_t  ctrl;
    word_t  op_a;
    word_t  op_b;

    // register file read ports, same cycle as inst
    assign rs_addr = inst[rs_lsb +: reg_w];
    assign rt_addr = inst[rt_lsb +: reg_w];

    instr_classifier instr_classifier_inst (
        .inst  (inst),
        .instr (instr)
    );

    ctrl_table ctrl_table_inst (
        .instr (instr),
        .inst  (inst),
        .ctrl  (ctrl)
    );

    operand_select operand_select_inst (
        .ctrl    (ctrl),
        .inst    (inst),
        .pc      (pc),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .op_a    (op_a),
        .op_b    (op_b)
    );

    id_issue id_issue_inst (
        .clk         (clk),
        .reset       (reset),
        .inst_valid  (inst_valid),
        .ctrl        (ctrl),
        .op_a        (op_a),
        .op_b        (op_b),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .issue_valid (issue_valid),
        .issue       (issue)
    );

endmodule

/* id_stage_tb.sv */
`timescale 1ns/1ps

module id_stage_tb;
    import mips_isa_pkg::*;
    import id_ctrl_pkg::*;

    typedef struct packed {
        logic   rand_data;  // pc and register data are don't-care
        word_t  inst;
        word_t  pc;
        word_t  rs_data;
        word_t  rt_data;
        issue_t exp;
    } test_t;

    typedef struct packed {
        logic        ops_known;
        logic [15:0] idx;
        issue_t      bundle;
    } expect_t;

    logic      clk;
    logic      reset;
    logic      inst_valid;
    word_t     inst;
    word_t     pc;
    word_t     rs_data;
    word_t     rt_data;
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    logic      issue_valid;
    issue_t    issue;

    test_t   tests[$];
    expect_t pending[$];
    expect_t popped;
    integer  seed;
    integer  errors;
    integer  strobes_sent;
    integer  issues_checked;
    integer  limit_ns;
    logic    loaded;

    id_stage id_stage_inst (
        .clk         (clk),
        .reset       (reset),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .pc          (pc),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .rs_addr     (rs_addr),
        .rt_addr     (rt_addr),
        .issue_valid (issue_valid),
        .issue       (issue)
    );

    always #5 clk = ~clk;

    task check_field(input string name, input logic [31:0] got, input logic [31:0] exp,
                     input string where);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h (%s)", name, got, exp, where);
            errors = errors + 1;
        end
    endtask

    task load_tests;
        integer fd;
        integer code;
        logic        done;
        logic [31:0] v [0:13];
        logic [8*256-1:0] skip_buf;
        test_t t;
        fd = $fopen("id_stage_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file id_stage_tests.txt");
            errors = errors + 1;
        end else begin
            done = 1'b0;
            while (!done) begin
                code = $fscanf(fd, "%h", v[0]);
                if (code == 1) begin
                    code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                                   v[1], v[2], v[3], v[4], v[5], v[6], v[7],
                                   v[8], v[9], v[10], v[11], v[12], v[13]);
                    if (code != 13) begin
                        $display("test data line after test %0d is incomplete", tests.size());
                        errors = errors + 1;
                        done = 1'b1;
                    end else begin
                        t.rand_data      = v[0][0];
                        t.inst           = v[1];
                        t.pc             = v[2];
                        t.rs_data        = v[3];
                        t.rt_data        = v[4];
                        t.exp.alu_op     = alu_op_e'(v[5][4:0]);
                        t.exp.op_a       = v[6];
                        t.exp.op_b       = v[7];
                        t.exp.mem_rd     = v[8][0];
                        t.exp.mem_wr     = v[9][0];
                        t.exp.reg_wr     = v[10][0];
                        t.exp.wb_sel     = wb_sel_e'(v[11][1:0]);
                        t.exp.reg_target = v[12][4:0];
                        t.exp.jump_en    = v[13][0];
                        tests.push_back(t);
                    end
                end else if (code == 0) begin
                    code = $fgets(skip_buf, fd);  // comment line
                    if (code == 0) done = 1'b1;
                end else begin
                    done = 1'b1;  // end of file
                end
            end
            $fclose(fd);
            if (tests.size() == 0) begin
                $display("no tests were found in id_stage_tests.txt");
                errors = errors + 1;
            end
        end
    endtask

    task apply_test(input test_t t, input integer idx);
        expect_t e;
        inst = t.inst;
        if (t.rand_data) begin
            pc      = $random(seed);
            rs_data = $random(seed);
            rt_data = $random(seed);
        end else begin
            pc      = t.pc;
            rs_data = t.rs_data;
            rt_data = t.rt_data;
        end
        inst_valid  = 1'b1;
        e.ops_known = !t.rand_data;
        e.idx       = idx;
        e.bundle    = t.exp;
        pending.push_back(e);
        strobes_sent = strobes_sent + 1;
    endtask

    task compare_issue(input expect_t e);
        string where;
        where = $sformatf("test %0d", e.idx);
        check_field("alu_op", issue.alu_op, e.bundle.alu_op, where);
        if (e.ops_known) begin
            check_field("op_a", issue.op_a, e.bundle.op_a, where);
            check_field("op_b", issue.op_b, e.bundle.op_b, where);
        end
        check_field("mem_rd", issue.mem_rd, e.bundle.mem_rd, where);
        check_field("mem_wr", issue.mem_wr, e.bundle.mem_wr, where);
        check_field("reg_wr", issue.reg_wr, e.bundle.reg_wr, where);
        check_field("wb_sel", issue.wb_sel, e.bundle.wb_sel, where);
        check_field("reg_target", issue.reg_target, e.bundle.reg_target, where);
        check_field("jump_en", issue.jump_en, e.bundle.jump_en, where);
        issues_checked = issues_checked + 1;
    endtask

    task finish_run;
        $display("closing: %0d errors, %0d strobes sent, %0d issues checked",
                 errors, strobes_sent, issues_checked);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    endtask

    // outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin
        if (!reset) begin
            if (issue_valid) begin
                if (pending.size() == 0) begin
                    $display("an issue arrived without a matching strobe");
                    errors = errors + 1;
                end else begin
                    popped = pending.pop_front();
                    compare_issue(popped);
                end
            end else if (strobes_sent == 0) begin
                check_field("idle op_a", issue.op_a, 32'h0, "before first strobe");
                check_field("idle op_b", issue.op_b, 32'h0, "before first strobe");
                check_field("idle control", {issue.alu_op, issue.mem_rd, issue.mem_wr,
                            issue.reg_wr, issue.wb_sel, issue.reg_target, issue.jump_en},
                            32'h0, "before first strobe");
            end
        end
    end

    initial begin
        wait (loaded);
        #(limit_ns);
        $display("timeout: %0d expected issues went missing", pending.size());
        errors = errors + 1;
        finish_run();
    end

    initial begin
        clk            = 1'b0;
        reset          = 1'b1;
        inst_valid     = 1'b0;
        inst           = '0;
        pc             = '0;
        rs_data        = '0;
        rt_data        = '0;
        seed           = 32'h9425;
        errors         = 0;
        strobes_sent   = 0;
        issues_checked = 0;
        loaded         = 1'b0;
        load_tests();
        limit_ns = (tests.size() + 40) * 10;
        loaded   = 1'b1;
        repeat (16) @(negedge clk);
        reset = 1'b0;
        repeat (4) @(negedge clk);  // idle, issue must stay zero
        foreach (tests[i]) begin
            apply_test(tests[i], i);
            @(posedge clk);
            check_field("rs_addr", rs_addr, inst[25:21], $sformatf("test %0d", i));
            check_field("rt_addr", rt_addr, inst[20:16], $sformatf("test %0d", i));
            @(negedge clk);
        end
        inst_valid = 1'b0;
        while (pending.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);  // catch stray issues
        finish_run();
    end

endmodule

/* id_stage_tests.txt */
# rnd inst pc rs_data rt_data | alu_op op_a op_b mem_rd mem_wr reg_wr wb_sel reg_target jump_en
# rnd 1 means pc and register data are random and op_a, op_b are not compared
0 00221820 00400000 11111111 22222222 01 11111111 22222222 0 0 1 1 03 0
0 00222022 00400004 a5a5a5a5 0f0f0f0f 02 a5a5a5a5 0f0f0f0f 0 0 1 1 04 0
0 00222824 00400008 ffff0000 12345678 03 ffff0000 12345678 0 0 1 1 05 0
0 00223025 0040000c 0000ffff 80000001 04 0000ffff 80000001 0 0 1 1 06 0
0 00223826 00400010 deadbeef 0badf00d 05 deadbeef 0badf00d 0 0 1 1 07 0
0 00024100 00400014 00000000 87654321 06 00000004 87654321 0 0 1 1 08 0
0 00025202 00400018 00000000 f0000000 07 00000008 f0000000 0 0 1 1 0a 0
0 00021fc3 0040001c 00000000 80000000 08 0000001f 80000000 0 0 1 1 03 0
0 2029fffc 00400020 00001000 00000000 01 00001000 fffffffc 0 0 1 1 09 0
0 302a8001 00400024 0000ffff 00000000 03 0000ffff 00008001 0 0 1 1 0a 0
0 3449f0f0 00400028 12340000 00000000 04 12340000 0000f0f0 0 0 1 1 09 0
0 388a1234 0040002c 00001234 00000000 05 00001234 00001234 0 0 1 1 0a 0
0 3c09abcd 00400030 00000000 00000000 0d abcd0000 00000000 0 0 1 1 09 0
0 8fa9fff8 00400034 7fff0000 00000000 09 7fff0000 fffffff8 1 0 1 2 09 0
0 afaa0010 00400038 7fff0000 cafebabe 0a 7fff0000 00000010 0 1 0 0 00 0
0 10220003 00400100 55555555 55555555 0b 00000003 00400100 0 0 0 0 00 1
0 1022fffe 00400104 55555555 55555554 0b fffffffe 00400104 0 0 0 0 00 0
0 14220010 00400108 00000000 00000000 0c 00000010 00400108 0 0 0 0 00 0
0 1422ffff 0040010c 00000001 00000000 0c ffffffff 0040010c 0 0 0 0 00 1
0 08100040 00400200 00000000 00000000 0e 00400200 00100040 0 0 0 0 00 1
0 0fffffff 00400204 00000000 00000000 0f 00400204 00000004 0 0 1 1 1f 1
0 03e00008 00400208 00400abc 00000000 10 00400abc 00000000 0 0 0 0 00 1
0 00224100 0040020c 11111111 22222222 00 00000000 00000000 0 0 0 0 00 0
0 fc221820 00400210 11111111 22222222 00 00000000 00000000 0 0 0 0 00 0
0 03e01808 00400214 00400abc 00000000 00 00000000 00000000 0 0 0 0 00 0
0 00221860 00400218 11111111 22222222 00 00000000 00000000 0 0 0 0 00 0
0 3c29abcd 0040021c 11111111 00000000 00 00000000 00000000 0 0 0 0 00 0
1 00221820 00000000 00000000 00000000 01 00000000 00000000 0 0 1 1 03 0
1 8fa9fff8 00000000 00000000 00000000 09 00000000 00000000 1 0 1 2 09 0
1 0fffffff 00000000 00000000 00000000 0f 00000000 00000000 0 0 1 1 1f 1

/* mips_id.f */
mips_isa_pkg.sv
id_ctrl_pkg.sv
instr_classifier.sv
ctrl_table.sv
operand_select.sv
id_issue.sv
id_stage.sv
id_stage_tb.sv
